// File: rtl/exec_cfg.svh
`ifndef EXEC_CFG_SVH
`define EXEC_CFG_SVH

// datapath widths, fixed by the rv32 format
`define XLEN 32
`define REG_ADDR_W 5
`define CSR_ADDR_W 12

// mpp = machine at reset
`define MSTATUS_RESET 32'h0000_1800

// environment call from m-mode
`define ECALL_CAUSE 32'd11

// mstatus interrupt enable bits
`define MSTATUS_MIE_BIT 3
`define MSTATUS_MPIE_BIT 7

`endif

// File: rtl/exec_pkg.sv
`default_nettype none

`include "exec_cfg.svh"

package exec_pkg;

	typedef logic [`XLEN-1:0] word_t;
	typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

	typedef enum logic [4:0] {
		OP_ADD,
		OP_SUB,
		OP_AND,
		OP_OR,
		OP_XOR,
		OP_SLL,
		OP_SRL,
		OP_SRA,
		OP_SLT,
		OP_SLTU,
		// conditional branches
		OP_BEQ,
		OP_BNE,
		OP_BLT,
		OP_BGE,
		OP_JAL,
		OP_JALR,
		// system ops, routed through the csr unit
		OP_CSRRW,
		OP_CSRRS,
		OP_ECALL,
		OP_MRET
	} exec_op_t;

	// only the machine trap csrs exist
	typedef enum logic [`CSR_ADDR_W-1:0] {
		CSR_MSTATUS = 12'h300,
		CSR_MTVEC = 12'h305,
		CSR_MEPC = 12'h341,
		CSR_MCAUSE = 12'h342
	} csr_addr_t;

endpackage

`default_nettype wire

// File: rtl/alu_unit.sv
`default_nettype none

`include "exec_cfg.svh"

module alu_unit (
	input wire exec_pkg::exec_op_t op_i,
	input wire exec_pkg::word_t pc_i,
	input wire exec_pkg::word_t src1_i,
	input wire exec_pkg::word_t src2_i,
	input wire exec_pkg::word_t imm_i,
	output exec_pkg::word_t result_o,
	output exec_pkg::word_t next_pc_o
);

	exec_pkg::word_t pc_plus4;
	exec_pkg::word_t pc_plus_imm;
	exec_pkg::word_t jalr_sum;
	exec_pkg::word_t jalr_target;
	logic [4:0] shamt;
	logic equal;
	logic signed_lt;
	logic unsigned_lt;
	logic branch_taken;

	assign pc_plus4 = pc_i + `XLEN'(4);
	assign pc_plus_imm = pc_i + imm_i;

	// jalr clears the low target bit
	assign jalr_sum = src1_i + imm_i;
	assign jalr_target = {jalr_sum[`XLEN-1:1], 1'b0};

	assign shamt = src2_i[4:0];

	assign equal = (src1_i == src2_i);
	assign signed_lt = ($signed(src1_i) < $signed(src2_i));
	assign unsigned_lt = (src1_i < src2_i);

	always_comb begin
		case (op_i)
			exec_pkg::OP_ADD: result_o = src1_i + src2_i;
			exec_pkg::OP_SUB: result_o = src1_i - src2_i;
			exec_pkg::OP_AND: result_o = src1_i & src2_i;
			exec_pkg::OP_OR: result_o = src1_i | src2_i;
			exec_pkg::OP_XOR: result_o = src1_i ^ src2_i;
			exec_pkg::OP_SLL: result_o = src1_i << shamt;
			exec_pkg::OP_SRL: result_o = src1_i >> shamt;
			exec_pkg::OP_SRA: result_o = exec_pkg::word_t'($signed(src1_i) >>> shamt);
			exec_pkg::OP_SLT: result_o = `XLEN'(signed_lt);
			exec_pkg::OP_SLTU: result_o = `XLEN'(unsigned_lt);
			// link value
			exec_pkg::OP_JAL,
			exec_pkg::OP_JALR: result_o = pc_plus4;
			default: result_o = '0;
		endcase
	end

	always_comb begin
		case (op_i)
			exec_pkg::OP_BEQ: branch_taken = equal;
			exec_pkg::OP_BNE: branch_taken = !equal;
			exec_pkg::OP_BLT: branch_taken = signed_lt;
			exec_pkg::OP_BGE: branch_taken = !signed_lt;
			default: branch_taken = 1'b0;
		endcase
	end

	// ecall and mret targets come from the csr side
	always_comb begin
		case (op_i)
			exec_pkg::OP_BEQ,
			exec_pkg::OP_BNE,
			exec_pkg::OP_BLT,
			exec_pkg::OP_BGE: begin
				next_pc_o = branch_taken ? pc_plus_imm : pc_plus4;
			end
			exec_pkg::OP_JAL: next_pc_o = pc_plus_imm;
			exec_pkg::OP_JALR: next_pc_o = jalr_target;
			default: next_pc_o = pc_plus4;
		endcase
	end

endmodule

`default_nettype wire

// File: rtl/csr_unit.sv
`default_nettype none

`include "exec_cfg.svh"

module csr_unit (
	input wire logic clock,
	input wire logic reset,
	input wire logic valid_i,
	input wire exec_pkg::exec_op_t op_i,
	input wire exec_pkg::word_t pc_i,
	input wire exec_pkg::word_t src1_i,
	input wire exec_pkg::csr_addr_t csr_addr_i,
	output exec_pkg::word_t rdata_o,
	output exec_pkg::word_t trap_pc_o
);

	exec_pkg::word_t mstatus;
	exec_pkg::word_t mtvec;
	exec_pkg::word_t mepc;
	exec_pkg::word_t mcause;
	exec_pkg::word_t wdata;
	logic write_req;

	// old value, before this cycle's write
	always_comb begin
		case (csr_addr_i)
			exec_pkg::CSR_MSTATUS: rdata_o = mstatus;
			exec_pkg::CSR_MTVEC: rdata_o = mtvec;
			exec_pkg::CSR_MEPC: rdata_o = mepc;
			exec_pkg::CSR_MCAUSE: rdata_o = mcause;
			default: rdata_o = '0;
		endcase
	end

	// csrrs with a zero mask leaves the csr alone
	always_comb begin
		case (op_i)
			exec_pkg::OP_CSRRW: begin
				wdata = src1_i;
				write_req = 1'b1;
			end
			exec_pkg::OP_CSRRS: begin
				wdata = rdata_o | src1_i;
				write_req = (src1_i != '0);
			end
			default: begin
				wdata = rdata_o;
				write_req = 1'b0;
			end
		endcase
	end

	assign trap_pc_o = (op_i == exec_pkg::OP_MRET) ? mepc : mtvec;

	always_ff @(posedge clock) begin
		if (reset) begin
			mstatus <= `MSTATUS_RESET;
			mtvec <= '0;
			mepc <= '0;
			mcause <= '0;
		end else if (valid_i) begin
			if (write_req) begin
				case (csr_addr_i)
					exec_pkg::CSR_MSTATUS: mstatus <= wdata;
					exec_pkg::CSR_MTVEC: mtvec <= wdata;
					exec_pkg::CSR_MEPC: mepc <= wdata;
					exec_pkg::CSR_MCAUSE: mcause <= wdata;
					// unimplemented address, write dropped
					default: begin
					end
				endcase
			end

			if (op_i == exec_pkg::OP_ECALL) begin
				mepc <= pc_i;
				mcause <= `ECALL_CAUSE;
				mstatus[`MSTATUS_MPIE_BIT] <= mstatus[`MSTATUS_MIE_BIT];
				mstatus[`MSTATUS_MIE_BIT] <= 1'b0;
			end else if (op_i == exec_pkg::OP_MRET) begin
				mstatus[`MSTATUS_MIE_BIT] <= mstatus[`MSTATUS_MPIE_BIT];
				mstatus[`MSTATUS_MPIE_BIT] <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: rtl/writeback_select.sv
`default_nettype none

module writeback_select (
	input wire logic clock,
	input wire logic reset,
	input wire logic valid_i,
	input wire exec_pkg::exec_op_t op_i,
	input wire exec_pkg::reg_addr_t rd_addr_i,
	input wire exec_pkg::word_t alu_result_i,
	input wire exec_pkg::word_t alu_next_pc_i,
	input wire exec_pkg::word_t csr_rdata_i,
	input wire exec_pkg::word_t trap_pc_i,
	output logic valid_o,
	output logic rd_wen_o,
	output exec_pkg::reg_addr_t rd_addr_o,
	output exec_pkg::word_t rd_data_o,
	output exec_pkg::word_t next_pc_o
);

	logic is_csr_rw;
	logic is_trap;
	logic writes_rd;
	exec_pkg::word_t sel_data;
	exec_pkg::word_t sel_pc;

	always_comb begin
		is_csr_rw = 1'b0;
		is_trap = 1'b0;
		writes_rd = 1'b0;
		case (op_i)
			exec_pkg::OP_CSRRW,
			exec_pkg::OP_CSRRS: begin
				is_csr_rw = 1'b1;
				writes_rd = 1'b1;
			end
			exec_pkg::OP_ECALL,
			exec_pkg::OP_MRET: is_trap = 1'b1;
			// branches have no destination
			exec_pkg::OP_BEQ,
			exec_pkg::OP_BNE,
			exec_pkg::OP_BLT,
			exec_pkg::OP_BGE: writes_rd = 1'b0;
			default: writes_rd = 1'b1;
		endcase
	end

	assign sel_data = is_csr_rw ? csr_rdata_i : alu_result_i;
	assign sel_pc = is_trap ? trap_pc_i : alu_next_pc_i;

	always_ff @(posedge clock) begin
		if (reset) begin
			valid_o <= 1'b0;
			rd_wen_o <= 1'b0;
		end else begin
			valid_o <= valid_i;
			// x0 is never written
			rd_wen_o <= valid_i && writes_rd && (rd_addr_i != '0);
		end
	end

	always_ff @(posedge clock) begin
		if (valid_i) begin
			rd_addr_o <= rd_addr_i;
			rd_data_o <= sel_data;
			next_pc_o <= sel_pc;
		end
	end

endmodule

`default_nettype wire

// File: rtl/exec_stage.sv
`default_nettype none

`include "exec_cfg.svh"

module exec_stage (
	input wire logic clock,
	input wire logic reset,
	input wire logic valid_i,
	input wire exec_pkg::exec_op_t op_i,
	input wire exec_pkg::word_t pc_i,
	input wire exec_pkg::word_t src1_i,
	input wire exec_pkg::word_t src2_i,
	input wire exec_pkg::word_t imm_i,
	input wire exec_pkg::reg_addr_t rd_addr_i,
	output logic valid_o,
	output logic rd_wen_o,
	output exec_pkg::reg_addr_t rd_addr_o,
	output exec_pkg::word_t rd_data_o,
	output exec_pkg::word_t next_pc_o
);

	exec_pkg::word_t alu_result;
	exec_pkg::word_t alu_next_pc;
	exec_pkg::word_t csr_rdata;
	exec_pkg::word_t trap_pc;
	exec_pkg::csr_addr_t csr_addr;

	// csr address rides in the low immediate bits
	assign csr_addr = exec_pkg::csr_addr_t'(imm_i[`CSR_ADDR_W-1:0]);

	alu_unit u_alu_unit (
		.op_i(op_i),
		.pc_i(pc_i),
		.src1_i(src1_i),
		.src2_i(src2_i),
		.imm_i(imm_i),
		.result_o(alu_result),
		.next_pc_o(alu_next_pc)
	);

	// csr state updates on the same edge that registers the result
	csr_unit u_csr_unit (
		.clock(clock),
		.reset(reset),
		.valid_i(valid_i),
		.op_i(op_i),
		.pc_i(pc_i),
		.src1_i(src1_i),
		.csr_addr_i(csr_addr),
		.rdata_o(csr_rdata),
		.trap_pc_o(trap_pc)
	);

	writeback_select u_writeback_select (
		.clock(clock),
		.reset(reset),
		.valid_i(valid_i),
		.op_i(op_i),
		.rd_addr_i(rd_addr_i),
		.alu_result_i(alu_result),
		.alu_next_pc_i(alu_next_pc),
		.csr_rdata_i(csr_rdata),
		.trap_pc_i(trap_pc),
		.valid_o(valid_o),
		.rd_wen_o(rd_wen_o),
		.rd_addr_o(rd_addr_o),
		.rd_data_o(rd_data_o),
		.next_pc_o(next_pc_o)
	);

endmodule

`default_nettype wire

// File: test/tb_exec_stage.sv
`default_nettype none

module tb_exec_stage;

	logic clock = 1'b0;
	logic reset;
	logic valid_i;
	exec_pkg::exec_op_t op_i;
	exec_pkg::word_t pc_i;
	exec_pkg::word_t src1_i;
	exec_pkg::word_t src2_i;
	exec_pkg::word_t imm_i;
	exec_pkg::reg_addr_t rd_addr_i;
	logic valid_o;
	logic rd_wen_o;
	exec_pkg::reg_addr_t rd_addr_o;
	exec_pkg::word_t rd_data_o;
	exec_pkg::word_t next_pc_o;

	// test table, one slot per entry in each queue
	string t_name[$];
	exec_pkg::exec_op_t t_op[$];
	exec_pkg::word_t t_pc[$];
	exec_pkg::word_t t_src1[$];
	exec_pkg::word_t t_src2[$];
	exec_pkg::word_t t_imm[$];
	exec_pkg::reg_addr_t t_rd[$];
	bit t_wen[$];
	bit t_chk_data[$];
	exec_pkg::word_t t_data[$];
	exec_pkg::word_t t_npc[$];

	int pass_count = 0;
	int fail_count = 0;
	int alu_count;
	int i;
	bit test_ok;
	bit timed_out;

	exec_stage u_exec_stage (
		.clock(clock),
		.reset(reset),
		.valid_i(valid_i),
		.op_i(op_i),
		.pc_i(pc_i),
		.src1_i(src1_i),
		.src2_i(src2_i),
		.imm_i(imm_i),
		.rd_addr_i(rd_addr_i),
		.valid_o(valid_o),
		.rd_wen_o(rd_wen_o),
		.rd_addr_o(rd_addr_o),
		.rd_data_o(rd_data_o),
		.next_pc_o(next_pc_o)
	);

	always #50 clock = ~clock;

	task automatic add_entry(input string name, input exec_pkg::exec_op_t op,
			input exec_pkg::word_t pc, input exec_pkg::word_t src1,
			input exec_pkg::word_t src2, input exec_pkg::word_t imm,
			input exec_pkg::reg_addr_t rd, input bit wen, input bit chk_data,
			input exec_pkg::word_t data, input exec_pkg::word_t npc);
		t_name.push_back(name);
		t_op.push_back(op);
		t_pc.push_back(pc);
		t_src1.push_back(src1);
		t_src2.push_back(src2);
		t_imm.push_back(imm);
		t_rd.push_back(rd);
		t_wen.push_back(wen);
		t_chk_data.push_back(chk_data);
		t_data.push_back(data);
		t_npc.push_back(npc);
	endtask

	task automatic check_word(input string name, input string field,
			input exec_pkg::word_t expected, input exec_pkg::word_t actual);
		if (actual !== expected) begin
			$display("[FAIL] %s %s: expected %h, actual %h", name, field, expected, actual);
			test_ok = 1'b0;
		end
	endtask

	task automatic check_wen(input string name, input string field,
			input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("[FAIL] %s %s: expected %b, actual %b", name, field, expected, actual);
			test_ok = 1'b0;
		end
	endtask

	task automatic check_addr(input string name, input exec_pkg::reg_addr_t expected,
			input exec_pkg::reg_addr_t actual);
		if (actual !== expected) begin
			$display("[FAIL] %s rd_addr: expected %0d, actual %0d", name, expected, actual);
			test_ok = 1'b0;
		end
	endtask

	task automatic drive_entry(input int idx);
		valid_i <= 1'b1;
		op_i <= t_op[idx];
		pc_i <= t_pc[idx];
		src1_i <= t_src1[idx];
		src2_i <= t_src2[idx];
		imm_i <= t_imm[idx];
		rd_addr_i <= t_rd[idx];
	endtask

	// outputs are sampled on the falling edge
	task automatic wait_for_valid(output bit expired);
		int cycles;
		cycles = 0;
		expired = 1'b0;
		@(negedge clock);
		while (valid_o !== 1'b1 && !expired) begin
			@(negedge clock);
			cycles++;
			if (cycles >= 20)
				expired = 1'b1;
		end
	endtask

	task automatic compare_entry(input int idx, input string name);
		test_ok = 1'b1;
		check_wen(name, "valid", 1'b1, valid_o);
		check_wen(name, "rd_wen", t_wen[idx], rd_wen_o);
		check_addr(name, t_rd[idx], rd_addr_o);
		if (t_chk_data[idx])
			check_word(name, "rd_data", t_data[idx], rd_data_o);
		check_word(name, "next_pc", t_npc[idx], next_pc_o);
		if (test_ok) begin
			pass_count++;
			$display("test %s: ok", name);
		end else begin
			fail_count++;
			$display("test %s: mismatch", name);
		end
	endtask

	task automatic build_table();
		// alu ops at pc 0x100
		add_entry("add", exec_pkg::OP_ADD, 32'h100, 32'd7, 32'd5, 32'h0, 5, 1, 1, 32'd12, 32'h104);
		add_entry("sub", exec_pkg::OP_SUB, 32'h100, 32'd5, 32'd7, 32'h0, 5, 1, 1,
			32'hffff_fffe, 32'h104);
		add_entry("and", exec_pkg::OP_AND, 32'h100, 32'hf0f0_f0f0, 32'hff00_ff00, 32'h0, 5,
			1, 1, 32'hf000_f000, 32'h104);
		add_entry("or", exec_pkg::OP_OR, 32'h100, 32'hf0f0_f0f0, 32'h0f0f_0000, 32'h0, 5,
			1, 1, 32'hffff_f0f0, 32'h104);
		add_entry("xor", exec_pkg::OP_XOR, 32'h100, 32'hffff_0000, 32'h0f0f_0f0f, 32'h0, 5,
			1, 1, 32'hf0f0_0f0f, 32'h104);
		// shift amount 0x21 keeps only its low five bits
		add_entry("sll", exec_pkg::OP_SLL, 32'h100, 32'd1, 32'h21, 32'h0, 5, 1, 1, 32'd2, 32'h104);
		add_entry("srl", exec_pkg::OP_SRL, 32'h100, 32'h8000_0000, 32'd4, 32'h0, 5, 1, 1,
			32'h0800_0000, 32'h104);
		add_entry("sra", exec_pkg::OP_SRA, 32'h100, 32'h8000_0000, 32'd4, 32'h0, 5, 1, 1,
			32'hf800_0000, 32'h104);
		add_entry("slt", exec_pkg::OP_SLT, 32'h100, 32'hffff_ffff, 32'd1, 32'h0, 5, 1, 1,
			32'd1, 32'h104);
		add_entry("sltu", exec_pkg::OP_SLTU, 32'h100, 32'hffff_ffff, 32'd1, 32'h0, 5, 1, 1,
			32'd0, 32'h104);
		add_entry("add_x0", exec_pkg::OP_ADD, 32'h100, 32'd7, 32'd5, 32'h0, 0, 0, 1,
			32'd12, 32'h104);
		alu_count = t_name.size();

		// branches, write enable stays low even with rd set
		add_entry("beq_taken", exec_pkg::OP_BEQ, 32'h200, 32'd5, 32'd5, 32'h40, 3, 0, 0, 0, 32'h240);
		add_entry("beq_not", exec_pkg::OP_BEQ, 32'h200, 32'd5, 32'd6, 32'h40, 3, 0, 0, 0, 32'h204);
		add_entry("bne_taken", exec_pkg::OP_BNE, 32'h200, 32'd5, 32'd6, 32'h40, 3, 0, 0, 0, 32'h240);
		add_entry("bne_not", exec_pkg::OP_BNE, 32'h200, 32'd5, 32'd5, 32'h40, 3, 0, 0, 0, 32'h204);
		add_entry("blt_taken", exec_pkg::OP_BLT, 32'h200, 32'hffff_ffff, 32'd1, 32'hffff_fff0, 3,
			0, 0, 0, 32'h1f0);
		add_entry("blt_not", exec_pkg::OP_BLT, 32'h200, 32'd1, 32'hffff_ffff, 32'h40, 3,
			0, 0, 0, 32'h204);
		add_entry("bge_taken", exec_pkg::OP_BGE, 32'h200, 32'd1, 32'hffff_ffff, 32'h40, 3,
			0, 0, 0, 32'h240);
		add_entry("bge_not", exec_pkg::OP_BGE, 32'h200, 32'hffff_ffff, 32'd1, 32'h40, 3,
			0, 0, 0, 32'h204);
		add_entry("jal", exec_pkg::OP_JAL, 32'h300, 32'h0, 32'h0, 32'h100, 1, 1, 1, 32'h304, 32'h400);
		add_entry("jalr", exec_pkg::OP_JALR, 32'h300, 32'h1001, 32'h0, 32'h4, 1, 1, 1,
			32'h304, 32'h1004);

		// csr sequence, order matters
		add_entry("csrrw_mtvec", exec_pkg::OP_CSRRW, 32'h400, 32'h800, 32'h0, 32'h305, 6,
			1, 1, 32'h0, 32'h404);
		add_entry("csrrs_mtvec", exec_pkg::OP_CSRRS, 32'h404, 32'h0, 32'h0, 32'h305, 6,
			1, 1, 32'h800, 32'h408);
		add_entry("csrrs_mtvec_again", exec_pkg::OP_CSRRS, 32'h408, 32'h0, 32'h0, 32'h305, 6,
			1, 1, 32'h800, 32'h40c);
		add_entry("csrrs_unimpl", exec_pkg::OP_CSRRS, 32'h40c, 32'hff, 32'h0, 32'h123, 6,
			1, 1, 32'h0, 32'h410);
		add_entry("csrrs_unimpl_read", exec_pkg::OP_CSRRS, 32'h410, 32'h0, 32'h0, 32'h123, 6,
			1, 1, 32'h0, 32'h414);
		add_entry("set_mie", exec_pkg::OP_CSRRS, 32'h414, 32'h8, 32'h0, 32'h300, 6,
			1, 1, 32'h1800, 32'h418);
		add_entry("ecall", exec_pkg::OP_ECALL, 32'h500, 32'h0, 32'h0, 32'h0, 7, 0, 0, 0, 32'h800);
		add_entry("read_mepc", exec_pkg::OP_CSRRS, 32'h800, 32'h0, 32'h0, 32'h341, 6,
			1, 1, 32'h500, 32'h804);
		add_entry("read_mcause", exec_pkg::OP_CSRRS, 32'h804, 32'h0, 32'h0, 32'h342, 6,
			1, 1, 32'd11, 32'h808);
		add_entry("read_mstatus_trap", exec_pkg::OP_CSRRS, 32'h808, 32'h0, 32'h0, 32'h300, 6,
			1, 1, 32'h1880, 32'h80c);
		add_entry("mret", exec_pkg::OP_MRET, 32'h900, 32'h0, 32'h0, 32'h0, 7, 0, 0, 0, 32'h500);
		add_entry("read_mstatus_ret", exec_pkg::OP_CSRRS, 32'h500, 32'h0, 32'h0, 32'h300, 6,
			1, 1, 32'h1888, 32'h504);
	endtask

	initial begin
		reset <= 1'b1;
		valid_i <= 1'b0;
		op_i <= exec_pkg::OP_ADD;
		pc_i <= '0;
		src1_i <= '0;
		src2_i <= '0;
		imm_i <= '0;
		rd_addr_i <= '0;
		timed_out = 1'b0;
		build_table();

		repeat (3) @(posedge clock);
		reset <= 1'b0;

		@(negedge clock);
		test_ok = 1'b1;
		check_wen("reset", "valid", 1'b0, valid_o);
		check_wen("reset", "rd_wen", 1'b0, rd_wen_o);
		if (test_ok) begin
			pass_count++;
			$display("test reset: ok");
		end else begin
			fail_count++;
			$display("test reset: mismatch");
		end

		for (i = 0; i < t_name.size(); i++) begin
			@(posedge clock);
			drive_entry(i);
			@(posedge clock);
			valid_i <= 1'b0;
			wait_for_valid(timed_out);
			if (timed_out) begin
				fail_count++;
				$display("test %s: valid_o did not rise within 20 cycles", t_name[i]);
				break;
			end
			compare_entry(i, t_name[i]);
		end

		// one strobe per cycle, each result lands the cycle after its input
		if (!timed_out) begin
			for (i = 0; i < alu_count; i++) begin
				@(posedge clock);
				drive_entry(i);
				if (i > 0) begin
					@(negedge clock);
					compare_entry(i - 1, $sformatf("stream_%s", t_name[i - 1]));
				end
			end
			@(posedge clock);
			valid_i <= 1'b0;
			@(negedge clock);
			compare_entry(alu_count - 1, $sformatf("stream_%s", t_name[alu_count - 1]));
		end

		$display("summary: %0d passed, %0d failed", pass_count, fail_count);
		if (fail_count == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: sources.f
+incdir+rtl
rtl/exec_pkg.sv
rtl/alu_unit.sv
rtl/csr_unit.sv
rtl/writeback_select.sv
rtl/exec_stage.sv
test/tb_exec_stage.sv
